// ==== hw/backend_pipe.sv ====
`timescale 1ns/1ns

module backend_pipe (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue_i,
	input  op_pkg::alu_op_e     op_i,
	input  logic                use_imm_i,
	input  op_pkg::br_type_e    br_type_i,
	input  op_pkg::wb_sel_e     wb_sel_i,
	input  logic                predict_taken_i,
	input  flow_pkg::data_t     pc_i,
	input  flow_pkg::data_t     imm_i,
	input  flow_pkg::data_t     rj_data_i,
	input  flow_pkg::data_t     rk_data_i,
	input  flow_pkg::fwd_src_t  fwd_j_i,
	input  flow_pkg::fwd_src_t  fwd_k_i,
	input  flow_pkg::reg_addr_t w_reg_i,
	input  flow_pkg::stage_vec_t stall_i,
	input  flow_pkg::stage_vec_t clear_i,
	output logic                redirect_o,
	output flow_pkg::data_t     redirect_pc_o,
	output flow_pkg::reg_addr_t reg_w_addr_o,
	output flow_pkg::data_t     reg_w_data_o
);
	import op_pkg::*;
	import flow_pkg::*;

	// ex -> m1
	logic      ex_valid;
	reg_addr_t ex_w_reg;
	wb_sel_e   ex_wb_sel;
	data_t     ex_result, ex_opnd_j, ex_opnd_k;

	// m1 -> m2
	logic           m1_valid;
	reg_addr_t      m1_w_reg;
	wb_sel_e        m1_wb_sel;
	data_t          m1_result;
	half_prod_t [3:0] m1_pp;

	// forwarding sources back into ex
	data_t m2_result, wb_result;

	ex_stage u_ex (
		.clk, .rst_n,
		.issue_i, .op_i, .use_imm_i, .br_type_i, .wb_sel_i, .predict_taken_i,
		.pc_i, .imm_i, .rj_data_i, .rk_data_i, .fwd_j_i, .fwd_k_i, .w_reg_i,
		.stall_i,
		.m1_result_i(m1_result), .m2_result_i(m2_result), .wb_result_i(wb_result),
		.redirect_o, .redirect_pc_o,
		.valid_o(ex_valid), .w_reg_o(ex_w_reg), .wb_sel_o(ex_wb_sel),
		.result_o(ex_result), .opnd_j_o(ex_opnd_j), .opnd_k_o(ex_opnd_k)
	);

	m1_stage u_m1 (
		.clk, .rst_n, .stall_i, .clear_i,
		.valid_i(ex_valid), .w_reg_i(ex_w_reg), .wb_sel_i(ex_wb_sel),
		.result_i(ex_result), .opnd_j_i(ex_opnd_j), .opnd_k_i(ex_opnd_k),
		.valid_o(m1_valid), .w_reg_o(m1_w_reg), .wb_sel_o(m1_wb_sel),
		.result_o(m1_result), .pp_o(m1_pp)
	);

	m2_stage u_m2 (
		.clk, .rst_n, .stall_i, .clear_i,
		.valid_i(m1_valid), .w_reg_i(m1_w_reg), .wb_sel_i(m1_wb_sel),
		.result_i(m1_result), .pp_i(m1_pp),
		.m2_result_o(m2_result), .wb_result_o(wb_result),
		.reg_w_addr_o, .reg_w_data_o
	);

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

module branch_unit (
	input  op_pkg::br_type_e br_type_i,
	input  logic             valid_i,
	input  logic             stall_i,
	input  logic             predict_taken_i,
	input  flow_pkg::data_t  pc_i,
	input  flow_pkg::data_t  imm_i,
	input  flow_pkg::data_t  rj_i,
	input  flow_pkg::data_t  rk_i,
	output flow_pkg::data_t  link_o,
	output logic             redirect_o,
	output flow_pkg::data_t  redirect_pc_o
);
	import op_pkg::*;
	import flow_pkg::*;

	logic  taken;
	data_t target;

	always_comb begin
		case (br_type_i)
			br_beq:  taken = (rj_i == rk_i);
			br_bne:  taken = (rj_i != rk_i);
			br_jirl: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// jirl is register relative, the rest pc relative
	assign target = ((br_type_i == br_jirl) ? rj_i : pc_i) + imm_i;
	assign link_o = pc_i + data_t'(`PIPE_PC_STEP);

	// one pulse per branch, only once ex lets it go
	assign redirect_o    = valid_i & ~stall_i & (br_type_i != br_none) & (taken != predict_taken_i);
	assign redirect_pc_o = taken ? target : link_o;

endmodule

// ==== hw/ex_alu.sv ====
`timescale 1ns/1ns

module ex_alu (
	input  op_pkg::alu_op_e  op_i,
	input  flow_pkg::data_t  a_i,
	input  flow_pkg::data_t  b_i,
	output flow_pkg::data_t  result_o
);
	import op_pkg::*;
	import flow_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed, lt_unsigned;

	assign shamt       = b_i[4:0];
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		unique case (op_i)
			alu_add:  result_o = a_i + b_i;
			alu_sub:  result_o = a_i - b_i;
			alu_and:  result_o = a_i & b_i;
			alu_or:   result_o = a_i | b_i;
			alu_xor:  result_o = a_i ^ b_i;
			alu_nor:  result_o = ~(a_i | b_i);
			alu_sll:  result_o = a_i << shamt;
			alu_srl:  result_o = a_i >> shamt;
			alu_sra:  result_o = data_t'($signed(a_i) >>> shamt);
			alu_slt:  result_o = data_t'(lt_signed);
			alu_sltu: result_o = data_t'(lt_unsigned);
			alu_lui:  result_o = b_i; // upper immediate comes in pre-shifted
			default:  result_o = '0;
		endcase
	end

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue_i,
	input  op_pkg::alu_op_e      op_i,
	input  logic                 use_imm_i,
	input  op_pkg::br_type_e     br_type_i,
	input  op_pkg::wb_sel_e      wb_sel_i,
	input  logic                 predict_taken_i,
	input  flow_pkg::data_t      pc_i,
	input  flow_pkg::data_t      imm_i,
	input  flow_pkg::data_t      rj_data_i,
	input  flow_pkg::data_t      rk_data_i,
	input  flow_pkg::fwd_src_t   fwd_j_i,
	input  flow_pkg::fwd_src_t   fwd_k_i,
	input  flow_pkg::reg_addr_t  w_reg_i,
	input  flow_pkg::stage_vec_t stall_i,
	input  flow_pkg::data_t      m1_result_i,
	input  flow_pkg::data_t      m2_result_i,
	input  flow_pkg::data_t      wb_result_i,
	output logic                 redirect_o,
	output flow_pkg::data_t      redirect_pc_o,
	output logic                 valid_o,
	output flow_pkg::reg_addr_t  w_reg_o,
	output op_pkg::wb_sel_e      wb_sel_o,
	output flow_pkg::data_t      result_o,
	output flow_pkg::data_t      opnd_j_o,
	output flow_pkg::data_t      opnd_k_o
);
	import op_pkg::*;
	import flow_pkg::*;

	logic      ex_valid;
	reg_addr_t ex_w_reg;
	wb_sel_e   ex_wb_sel;
	br_type_e  ex_br_type;
	fwd_src_t  ex_fwd_j, ex_fwd_k;
	alu_op_e   ex_op;
	logic      ex_use_imm, ex_predict;
	data_t     ex_pc, ex_imm, ex_rj, ex_rk;

	data_t alu_b, alu_result, link;

	// one-hot and-or pick of an operand
	function automatic data_t fwd_pick(fwd_src_t sel, data_t own, data_t m1, data_t m2,
		data_t wb);
		data_t val;
		val = '0;
		if (sel[0]) val = val | own;
		if (sel[1]) val = val | m1;
		if (sel[2]) val = val | m2;
		if (sel[3]) val = val | wb;
		return val;
	endfunction

	// follow the producer down the pipe while ex is held
	// m1 -> m2 -> wb -> own register
	function automatic fwd_src_t retarget(fwd_src_t sel, stage_vec_t stall);
		if ((sel[1] & ~stall[1]) | (sel[2] & ~stall[2]) | sel[3])
			return {sel[2:1], 1'b0, ~|sel[2:1]};
		return sel;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid   <= 1'b0;
			ex_w_reg   <= '0;
			ex_wb_sel  <= wb_alu;
			ex_br_type <= br_none;
			ex_fwd_j   <= 4'b0001;
			ex_fwd_k   <= 4'b0001;
		end else if (!stall_i[0]) begin
			ex_valid   <= issue_i;
			ex_w_reg   <= issue_i ? w_reg_i : '0;
			ex_wb_sel  <= issue_i ? wb_sel_i : wb_alu;
			ex_br_type <= issue_i ? br_type_i : br_none; // bubble never redirects
			ex_fwd_j   <= issue_i ? fwd_j_i : 4'b0001;
			ex_fwd_k   <= issue_i ? fwd_k_i : 4'b0001;
		end else begin
			ex_fwd_j <= retarget(ex_fwd_j, stall_i);
			ex_fwd_k <= retarget(ex_fwd_k, stall_i);
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i[0]) begin
			ex_op      <= op_i;
			ex_use_imm <= use_imm_i;
			ex_predict <= predict_taken_i;
			ex_pc      <= pc_i;
			ex_imm     <= imm_i;
			ex_rj      <= rj_data_i;
			ex_rk      <= rk_data_i;
		end else begin
			// keep whatever was forwarded this cycle
			ex_rj <= opnd_j_o;
			ex_rk <= opnd_k_o;
		end
	end

	assign opnd_j_o = fwd_pick(ex_fwd_j, ex_rj, m1_result_i, m2_result_i, wb_result_i);
	assign opnd_k_o = fwd_pick(ex_fwd_k, ex_rk, m1_result_i, m2_result_i, wb_result_i);

	assign alu_b = ex_use_imm ? ex_imm : opnd_k_o;

	ex_alu u_alu (
		.op_i(ex_op),
		.a_i(opnd_j_o),
		.b_i(alu_b),
		.result_o(alu_result)
	);

	branch_unit u_br (
		.br_type_i(ex_br_type),
		.valid_i(ex_valid),
		.stall_i(stall_i[0]),
		.predict_taken_i(ex_predict),
		.pc_i(ex_pc),
		.imm_i(ex_imm),
		.rj_i(opnd_j_o),
		.rk_i(opnd_k_o),
		.link_o(link),
		.redirect_o,
		.redirect_pc_o
	);

	assign valid_o  = ex_valid;
	assign w_reg_o  = ex_w_reg;
	assign wb_sel_o = ex_wb_sel;
	assign result_o = (ex_wb_sel == wb_link) ? link : alu_result;

endmodule

// ==== hw/flow_pkg.sv ====
`include "pipe_defines.svh"

package flow_pkg;

	// register, pc, immediate and result values
	typedef logic [`PIPE_XLEN-1:0] data_t;

	typedef logic [`PIPE_REG_AW-1:0] reg_addr_t;

	// one-hot forwarding source
	// bit 0 own operand, bit 1 m1, bit 2 m2, bit 3 wb
	typedef logic [`PIPE_FWD_NUM-1:0] fwd_src_t;

	// per-stage stall and clear bits
	typedef logic [`PIPE_STAGE_NUM-1:0] stage_vec_t;

	// 16x16 partial product
	typedef logic [`PIPE_XLEN-1:0] half_prod_t;

endpackage

// ==== hw/m1_stage.sv ====
`timescale 1ns/1ns

module m1_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  flow_pkg::stage_vec_t  stall_i,
	input  flow_pkg::stage_vec_t  clear_i,
	input  logic                  valid_i,
	input  flow_pkg::reg_addr_t   w_reg_i,
	input  op_pkg::wb_sel_e       wb_sel_i,
	input  flow_pkg::data_t       result_i,
	input  flow_pkg::data_t       opnd_j_i,
	input  flow_pkg::data_t       opnd_k_i,
	output logic                  valid_o,
	output flow_pkg::reg_addr_t   w_reg_o,
	output op_pkg::wb_sel_e       wb_sel_o,
	output flow_pkg::data_t       result_o,
	output flow_pkg::half_prod_t [3:0] pp_o
);
	import op_pkg::*;
	import flow_pkg::*;

	localparam int HALF = 16;

	data_t opnd_j_q, opnd_k_q;
	logic  take_bubble;

	assign take_bubble = stall_i[0] | clear_i[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_o  <= 1'b0;
			w_reg_o  <= '0;
			wb_sel_o <= wb_alu;
		end else if (!stall_i[1]) begin
			valid_o  <= take_bubble ? 1'b0 : valid_i;
			w_reg_o  <= take_bubble ? '0 : w_reg_i;
			wb_sel_o <= take_bubble ? wb_alu : wb_sel_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i[1]) begin
			result_o <= result_i;
			opnd_j_q <= opnd_j_i;
			opnd_k_q <= opnd_k_i;
		end
	end

	// unsigned 16x16 slices summed in m2
	assign pp_o[0] = opnd_j_q[HALF-1:0] * opnd_k_q[HALF-1:0];          // lo.lo
	assign pp_o[1] = opnd_j_q[HALF-1:0] * opnd_k_q[2*HALF-1:HALF];     // lo.hi
	assign pp_o[2] = opnd_j_q[2*HALF-1:HALF] * opnd_k_q[HALF-1:0];     // hi.lo
	assign pp_o[3] = opnd_j_q[2*HALF-1:HALF] * opnd_k_q[2*HALF-1:HALF]; // hi.hi

endmodule

// ==== hw/m2_stage.sv ====
`timescale 1ns/1ns

module m2_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  flow_pkg::stage_vec_t  stall_i,
	input  flow_pkg::stage_vec_t  clear_i,
	input  logic                  valid_i,
	input  flow_pkg::reg_addr_t   w_reg_i,
	input  op_pkg::wb_sel_e       wb_sel_i,
	input  flow_pkg::data_t       result_i,
	input  flow_pkg::half_prod_t [3:0] pp_i,
	output flow_pkg::data_t       m2_result_o,
	output flow_pkg::data_t       wb_result_o,
	output flow_pkg::reg_addr_t   reg_w_addr_o,
	output flow_pkg::data_t       reg_w_data_o
);
	import op_pkg::*;
	import flow_pkg::*;

	logic             m2_valid;
	reg_addr_t        m2_w_reg;
	wb_sel_e          m2_wb_sel;
	data_t            m2_result;
	half_prod_t [3:0] m2_pp;
	logic [63:0]      prod_full;

	reg_addr_t wb_w_reg;
	data_t     wb_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m2_valid  <= 1'b0;
			m2_w_reg  <= '0;
			m2_wb_sel <= wb_alu;
		end else if (!stall_i[2]) begin
			if (stall_i[1] | clear_i[1]) begin
				m2_valid  <= 1'b0;
				m2_w_reg  <= '0;
				m2_wb_sel <= wb_alu;
			end else begin
				m2_valid  <= valid_i;
				m2_w_reg  <= w_reg_i;
				m2_wb_sel <= wb_sel_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i[2]) begin
			m2_result <= result_i;
			m2_pp     <= pp_i;
		end
	end

	// only the low word is written back
	assign prod_full = {m2_pp[3], 32'd0} + {16'd0, m2_pp[2], 16'd0}
		+ {16'd0, m2_pp[1], 16'd0} + {32'd0, m2_pp[0]};

	assign m2_result_o = (m2_wb_sel == wb_mul) ? prod_full[31:0] : m2_result;

	// wb register, never stalled
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_w_reg <= '0;
		end else if (stall_i[2] | clear_i[2]) begin
			wb_w_reg <= '0;
		end else begin
			wb_w_reg <= m2_valid ? m2_w_reg : '0;
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= m2_result_o;
	end

	assign wb_result_o  = wb_data;
	assign reg_w_addr_o = wb_w_reg;
	assign reg_w_data_o = wb_data;

endmodule

// ==== hw/op_pkg.sv ====
package op_pkg;

	// alu operation codes
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_nor  = 4'd5,
		alu_sll  = 4'd6,
		alu_srl  = 4'd7,
		alu_sra  = 4'd8,
		alu_slt  = 4'd9,
		alu_sltu = 4'd10,
		alu_lui  = 4'd11  // passes operand b
	} alu_op_e;

	typedef enum logic [1:0] {
		br_none = 2'd0,
		br_beq  = 2'd1,
		br_bne  = 2'd2,
		br_jirl = 2'd3
	} br_type_e;

	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_link = 2'd1,
		wb_mul  = 2'd2  // product only valid from m2 on
	} wb_sel_e;

endpackage

// ==== hw/pipe_defines.svh ====
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// datapath width
`define PIPE_XLEN 32

// register file address width, r0 means no write
`define PIPE_REG_AW 5

// stall/clear bits: 0 ex, 1 m1, 2 m2
`define PIPE_STAGE_NUM 3

`define PIPE_FWD_NUM 4 // own, m1, m2, wb

`define PIPE_PC_STEP 4

`endif

// ==== tb/tb_backend_pipe.sv ====
`timescale 1ns/1ns

module tb_backend_pipe;
	import op_pkg::*;
	import flow_pkg::*;

	typedef struct packed {
		reg_addr_t addr;
		data_t     data;
	} write_t;

	logic       clk, rst_n, issue_i, use_imm_i, predict_taken_i, redirect_o;
	alu_op_e    op_i;
	br_type_e   br_type_i;
	wb_sel_e    wb_sel_i;
	data_t      pc_i, imm_i, rj_data_i, rk_data_i, redirect_pc_o, reg_w_data_o;
	fwd_src_t   fwd_j_i, fwd_k_i;
	reg_addr_t  w_reg_i, reg_w_addr_o;
	stage_vec_t stall_i, clear_i;

	logic [15:0] lfsr;
	data_t       regs [32];      // register file as the issue side sees it
	int          last_slot [32]; // slot of the last producer per register
	int          slot, errors, checks, tests, failed;
	data_t       pc_cnt, drv_rpc, ex_rpc;
	logic        drv_redir, ex_redir;
	write_t      exp_q [$];

	backend_pipe uut (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (rst_n && !stall_i[0])
			slot <= slot + 1; // one slot per accepted issue or bubble
	end

	// expected redirect of whatever sits in ex
	always @(posedge clk) begin
		if (!rst_n) begin
			ex_redir <= 1'b0;
		end else if (!stall_i[0]) begin
			ex_redir <= issue_i & drv_redir;
			ex_rpc   <= drv_rpc;
		end
	end

	always @(negedge clk) begin
		write_t w;
		if (rst_n) begin
			checks++;
			assert (redirect_o === (ex_redir & ~stall_i[0])) else begin
				$display("** Error at %0t: redirect_o expected %b got %b", $time,
					ex_redir & ~stall_i[0], redirect_o);
				errors++;
			end
			if (ex_redir && !stall_i[0]) begin
				assert (redirect_pc_o === ex_rpc) else begin
					$display("** Error at %0t: redirect_pc_o expected %h got %h", $time,
						ex_rpc, redirect_pc_o);
					errors++;
				end
			end
			if (reg_w_addr_o != '0) begin
				if (exp_q.size() == 0) begin
					$display("write to r%0d at %0t that nothing issued", reg_w_addr_o, $time);
					errors++;
				end else begin
					w = exp_q.pop_front();
					checks++;
					assert (reg_w_addr_o === w.addr) else begin
						$display("** Error at %0t: reg_w_addr_o expected %0d got %0d", $time,
							w.addr, reg_w_addr_o);
						errors++;
					end
					assert (reg_w_data_o === w.data) else begin
						$display("** Error at %0t: reg_w_data_o expected %h got %h", $time,
							w.data, reg_w_data_o);
						errors++;
					end
				end
			end
		end
	end

	// fibonacci lfsr, x^16+x^14+x^13+x^11+1
	function automatic data_t rand_bits(int n);
		data_t val;
		logic  fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic alu_op_e rand_op();
		return alu_op_e'(rand_bits(4) % 12);
	endfunction

	function automatic data_t alu_ref(alu_op_e op, data_t a, data_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			alu_add:  return a + b;
			alu_sub:  return a + ~b + 1;
			alu_and:  return a & b;
			alu_or:   return a | b;
			alu_xor:  return a ^ b;
			alu_nor:  return ~a & ~b;
			alu_sll:  return a << sh;
			alu_srl:  return a >> sh;
			alu_sra:  return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
			alu_slt:  return data_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)); // flip sign
			alu_sltu: return data_t'(a < b);
			default:  return b; // lui
		endcase
	endfunction

	// where the producer sits once the consumer reaches ex
	function automatic fwd_src_t src_sel(int r);
		int d;
		d = slot - last_slot[r];
		if (r == 0 || d > 3)
			return 4'b0001;
		return 4'b0001 << d;
	endfunction

	task automatic issue_op(alu_op_e op, logic use_imm, br_type_e br, wb_sel_e wsel,
		logic pred, data_t imm, int rj, int rk, int wd, logic doomed);
		data_t  a, b, res, target;
		logic   taken;
		write_t w;
		@(posedge clk);
		#1;
		a = regs[rj];
		b = regs[rk];
		fwd_j_i = src_sel(rj);
		fwd_k_i = src_sel(rk);
		rj_data_i = fwd_j_i[0] ? a : rand_bits(32); // stale when forwarded
		rk_data_i = fwd_k_i[0] ? b : rand_bits(32);
		issue_i = 1'b1;
		op_i = op;
		use_imm_i = use_imm;
		br_type_i = br;
		wb_sel_i = wsel;
		predict_taken_i = pred;
		pc_i = pc_cnt;
		imm_i = imm;
		w_reg_i = reg_addr_t'(wd);
		stall_i = '0;
		clear_i = '0;
		case (br)
			br_beq:  taken = (a == b);
			br_bne:  taken = (a != b);
			default: taken = (br == br_jirl);
		endcase
		target = (br == br_jirl) ? a + imm : pc_cnt + imm;
		drv_redir = (br != br_none) && (taken != pred);
		drv_rpc = taken ? target : pc_cnt + 4;
		if (wsel == wb_mul)
			res = a * b;
		else if (wsel == wb_link)
			res = pc_cnt + 4;
		else
			res = alu_ref(op, a, use_imm ? imm : b);
		if (!doomed && wd != 0) begin
			regs[wd] = res;
			last_slot[wd] = slot;
			w.addr = reg_addr_t'(wd);
			w.data = res;
			exp_q.push_back(w);
		end
		pc_cnt = pc_cnt + 4;
	endtask

	task automatic idle(stage_vec_t st, stage_vec_t cl);
		@(posedge clk);
		#1;
		issue_i = 1'b0;
		drv_redir = 1'b0;
		stall_i = st;
		clear_i = cl;
	endtask

	task automatic drain();
		int n;
		n = 0;
		idle('0, '0);
		while (exp_q.size() != 0 && n < 40) begin
			idle('0, '0);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d expected writes never reached the write port", exp_q.size());
			errors++;
			exp_q.delete();
		end
		repeat (4) idle('0, '0); // everything older now reads as own
	endtask

	task automatic report(string name, int err0);
		tests++;
		if (errors == err0) begin
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: %0d errors", name, errors - err0);
		end
	endtask

	task automatic reset_idle_test();
		int err0;
		err0 = errors;
		repeat (16) idle('0, '0);
		report("idle after reset", err0);
	endtask

	task automatic random_alu_test();
		int err0;
		err0 = errors;
		for (int i = 0; i < 60; i++)
			issue_op(alu_op_e'(i % 12), rand_bits(1), br_none, wb_alu, 1'b0, rand_bits(32),
				rand_bits(5), rand_bits(5), 1 + rand_bits(5) % 31, 1'b0);
		drain();
		report("random alu ops", err0);
	endtask

	task automatic forward_chain_test();
		int err0;
		err0 = errors;
		for (int g = 0; g < 4; g++) begin
			issue_op(rand_op(), 1'b1, br_none, wb_alu, 1'b0, rand_bits(32), 2, 0, 5, 1'b0);
			repeat (g) idle('0, '0);
			issue_op(alu_sub, 1'b0, br_none, wb_alu, 1'b0, '0, 5, 7, 6, 1'b0);
			issue_op(alu_xor, 1'b0, br_none, wb_alu, 1'b0, '0, 9, 5, 8, 1'b0);
		end
		// mul producers only reach ex from m2 on
		for (int g = 1; g < 4; g++) begin
			issue_op(alu_add, 1'b0, br_none, wb_mul, 1'b0, '0, 11, 12, 10, 1'b0);
			repeat (g) idle('0, '0);
			issue_op(alu_add, 1'b0, br_none, wb_alu, 1'b0, '0, 10, 14, 13, 1'b0);
			issue_op(alu_sub, 1'b0, br_none, wb_alu, 1'b0, '0, 14, 10, 15, 1'b0);
		end
		for (int i = 0; i < 10; i++)
			issue_op(rand_op(), 1'b0, br_none, wb_alu, 1'b0, '0, 15 + i, 14 + i, 16 + i, 1'b0);
		drain();
		report("forwarding chains", err0);
	endtask

	task automatic stall_retarget_test();
		int err0;
		err0 = errors;
		for (int i = 0; i < 12; i++) begin
			if (i % 3 == 2) begin
				issue_op(alu_add, 1'b0, br_none, wb_mul, 1'b0, '0, 3, 4, 20, 1'b0);
				idle('0, '0);
			end else begin
				issue_op(rand_op(), 1'b1, br_none, wb_alu, 1'b0, rand_bits(32), 3, 0, 20, 1'b0);
				if (i % 2)
					idle('0, '0);
			end
			issue_op(rand_op(), 1'b0, br_none, wb_alu, 1'b0, '0, 20, (i % 4 == 0) ? 20 : 21,
				22, 1'b0);
			// consumer held in ex, m1 only ever stalled together with ex
			repeat (1 + rand_bits(3)) idle(rand_bits(1) ? 3'b011 : 3'b001, '0);
			drain();
		end
		report("stall re-targeting", err0);
	endtask

	task automatic multiply_test();
		int err0;
		err0 = errors;
		for (int i = 0; i < 20; i++) begin
			issue_op(alu_add, 1'b0, br_none, wb_mul, 1'b0, '0, rand_bits(5), rand_bits(5),
				1 + rand_bits(5) % 31, 1'b0);
			idle('0, '0); // no mul result one slot ahead
		end
		drain();
		report("multiply", err0);
	endtask

	task automatic branch_test();
		int       err0, rj;
		br_type_e br;
		err0 = errors;
		for (int i = 0; i < 24; i++) begin
			br = br_type_e'(1 + rand_bits(2) % 3);
			rj = 1 + rand_bits(4);
			if (br == br_jirl)
				issue_op(alu_add, 1'b0, br, wb_link, rand_bits(1), rand_bits(16), rj, rj,
					16 + rand_bits(4), 1'b0);
			else
				issue_op(alu_add, 1'b0, br, wb_alu, rand_bits(1), rand_bits(16), rj,
					rand_bits(1) ? rj : 1 + rand_bits(4), 0, 1'b0);
		end
		drain();
		// mispredicted jirl, then clear the follower on its way out of ex
		for (int i = 0; i < 4; i++) begin
			issue_op(alu_add, 1'b0, br_jirl, wb_link, 1'b0, rand_bits(16), 2, 0, 26, 1'b0);
			issue_op(alu_or, 1'b1, br_none, wb_alu, 1'b0, rand_bits(32), 1, 0, 27, 1'b1);
			idle('0, 3'b001);
			drain();
		end
		report("branches and clear", err0);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		issue_i = 1'b0;
		op_i = alu_add;
		use_imm_i = 1'b0;
		br_type_i = br_none;
		wb_sel_i = wb_alu;
		predict_taken_i = 1'b0;
		pc_i = '0;
		imm_i = '0;
		rj_data_i = '0;
		rk_data_i = '0;
		fwd_j_i = 4'b0001;
		fwd_k_i = 4'b0001;
		w_reg_i = '0;
		stall_i = '0;
		clear_i = '0;
		lfsr = 16'd34;
		slot = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed = 0;
		drv_redir = 1'b0;
		drv_rpc = '0;
		pc_cnt = 32'h1c00_0000;
		for (int r = 0; r < 32; r++) begin
			regs[r] = (r == 0) ? '0 : rand_bits(32);
			last_slot[r] = -100;
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_idle_test();
		random_alu_test();
		forward_chain_test();
		stall_retarget_test();
		multiply_test();
		branch_test();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/op_pkg.sv
hw/flow_pkg.sv
hw/ex_alu.sv
hw/branch_unit.sv
hw/ex_stage.sv
hw/m1_stage.sv
hw/m2_stage.sv
hw/backend_pipe.sv
tb/tb_backend_pipe.sv
